//--- include/delay_macros.svh
`ifndef DELAY_MACROS_SVH
`define DELAY_MACROS_SVH

// ---------------------------------------------------------------------------
// Data path widths
// ---------------------------------------------------------------------------

// Raw delay count in clock cycles
`define DELAY_IN_W      16
// Average output, integer part in the upper 16 bits
`define DELAY_OUT_W     32

// Averager time constants, T = 2^N
`define DELAY_N_FAST    4
`define DELAY_N_SLOW    8
// Extra fractional bits kept in the accumulator
`define DELAY_PREC      16

// Count at which a measurement gives up
`define DELAY_MAX_CYC   65535

// ---------------------------------------------------------------------------
// AXI4-Lite register bus
// ---------------------------------------------------------------------------
`define DELAY_AXI_AW    8
`define DELAY_AXI_DW    32

`endif

//--- hdl/delay_pkg.sv
`include "delay_macros.svh"

package delay_pkg;

    // -----------------------------------------------------------------------
    // Data types
    // -----------------------------------------------------------------------

    // One raw delay in clock cycles
    typedef logic [`DELAY_IN_W-1:0] sample_t;

    // Smoothed delay, fixed point with integer in the upper half
    typedef logic [`DELAY_OUT_W-1:0] avg_t;

    // -----------------------------------------------------------------------
    // Counter FSM
    // -----------------------------------------------------------------------

    // Idle until start, armed until stop or timeout
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_ARMED = 1'b1
    } cnt_state_e;

    // -----------------------------------------------------------------------
    // Register map, byte addresses
    // -----------------------------------------------------------------------
    typedef enum logic [`DELAY_AXI_AW-1:0] {
        // bit0 enable, bit1 slow
        REG_CTRL   = 8'h00,
        // bit0 overrun0, bit1 overrun1, write 1 to clear
        REG_STATUS = 8'h04,
        REG_AVG0   = 8'h08,
        REG_AVG1   = 8'h0C,
        // avg0 - avg1, two's complement
        REG_DIFF   = 8'h10,
        // Samples since reset
        REG_COUNT  = 8'h14
    } reg_addr_e;

endpackage

//--- hdl/delay_meas_if.sv
`timescale 1ns/1ps

interface delay_meas_if;
    import delay_pkg::*;

    // One cycle pulse per finished measurement
    logic    strobe;
    // Valid only while strobe is high
    sample_t sample;
    logic    overrun;
    // Running average, held between updates
    avg_t    avg;

    // Counter side produces the raw sample
    modport counter (
        output strobe,
        output sample,
        output overrun
    );

    // Averager consumes the sample and produces avg
    modport averager (
        input  strobe,
        input  sample,
        output avg
    );

    // Combiner only watches the results
    modport monitor (
        input  strobe,
        input  overrun,
        input  avg
    );

endinterface

//--- hdl/delay_counter.sv
`timescale 1ns/1ps
`include "delay_macros.svh"

module delay_counter (
    input logic           clk,
    input logic           rst,
    input logic           enable,
    input logic           start,
    input logic           stop,
    delay_meas_if.counter meas
);
    import delay_pkg::*;

    // Timeout value in counter width
    localparam sample_t MAX_CYC = `DELAY_IN_W'(`DELAY_MAX_CYC);

    cnt_state_e state;
    // Cycles since start, 1 in the cycle after start
    sample_t    cnt;
    logic       arm;
    logic       done;

    // Start is ignored while disabled and restarts an armed count
    assign arm  = enable && start;
    // Stop or timeout ends an armed measurement
    assign done = (state == ST_ARMED) && (stop || cnt == MAX_CYC);

    // -----------------------------------------------------------------------
    // FSM and strobe
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            meas.strobe <= 1'b0;
        end else begin
            meas.strobe <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Stop while idle falls through here
                    if (arm) begin
                        state <= ST_ARMED;
                    end
                end
                ST_ARMED: begin
                    if (arm) begin
                        state <= ST_ARMED;
                    end else if (done) begin
                        state       <= ST_IDLE;
                        meas.strobe <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // -----------------------------------------------------------------------
    // Cycle counter and sample capture
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (arm) begin
            cnt <= sample_t'(1);
        end else if (state == ST_ARMED) begin
            cnt <= cnt + sample_t'(1);
        end
        // Last armed cycle leaves the value seen with strobe
        if (state == ST_ARMED) begin
            meas.sample  <= cnt;
            meas.overrun <= (cnt == MAX_CYC);
        end
    end

    // One strobe per measurement, never back to back
    a_strobe_single: assert property (
        @(posedge clk) disable iff (rst) meas.strobe |=> !meas.strobe
    );

endmodule

//--- hdl/delay_average.sv
`timescale 1ns/1ps
`include "delay_macros.svh"

module delay_average (
    input logic            clk,
    input logic            rst,
    input logic            slow,
    delay_meas_if.averager meas
);
    // Accumulator with headroom for the slow constant and extra fraction
    localparam int ACC_W = `DELAY_OUT_W + `DELAY_N_SLOW + `DELAY_PREC;
    // Output alignment to the top of the average word
    localparam int ALIGN = `DELAY_OUT_W - `DELAY_IN_W;
    // Sample shifts for both modes
    localparam int SH_SLOW = `DELAY_PREC;
    localparam int SH_FAST = `DELAY_PREC + `DELAY_N_SLOW - `DELAY_N_FAST;

    typedef logic [ACC_W-1:0] acc_t;

    acc_t         acc;
    acc_t         fdb;
    acc_t         smp;
    acc_t         aligned;
    // One extra bit to catch a carry out
    logic [ACC_W:0] acc_nxt;

    // -----------------------------------------------------------------------
    // y(n) = y(n-1) - y(n-1)/2^N + x(n) scaled
    // -----------------------------------------------------------------------
    assign fdb = slow ? (acc >> `DELAY_N_SLOW) : (acc >> `DELAY_N_FAST);
    // Fast input is scaled up so both modes settle to the same level
    assign smp = slow ? (acc_t'(meas.sample) << SH_SLOW)
                      : (acc_t'(meas.sample) << SH_FAST);
    assign acc_nxt = {1'b0, acc} - {1'b0, fdb} + {1'b0, smp};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (meas.strobe) begin
            acc <= acc_nxt[ACC_W-1:0];
        end
    end

    // Top bits of the shifted accumulator, integer in the upper half
    assign aligned  = acc << ALIGN;
    assign meas.avg = aligned[ACC_W-1 -: `DELAY_OUT_W];

    // A constant input settles well below the accumulator limit
    a_acc_no_ovf: assert property (
        @(posedge clk) disable iff (rst) meas.strobe |-> !acc_nxt[ACC_W]
    );

endmodule

//--- hdl/delay_combine.sv
`timescale 1ns/1ps

module delay_combine (
    input  logic             clk,
    input  logic             rst,
    delay_meas_if.monitor    ch0,
    delay_meas_if.monitor    ch1,
    input  logic [1:0]       clr_ovr,
    output delay_pkg::avg_t  diff,
    output logic [31:0]      count,
    output logic [1:0]       ovr
);
    // Channel 0 strobe delayed to line up with the new average
    logic       strobe_d;
    // Overrun events seen this cycle, one bit per channel
    logic [1:0] ovr_set;

    assign ovr_set = {ch1.strobe & ch1.overrun, ch0.strobe & ch0.overrun};

    // -----------------------------------------------------------------------
    // Difference and sample counter
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            diff     <= '0;
            count    <= '0;
            strobe_d <= 1'b0;
        end else begin
            // Wraps modulo 2^32, read back as signed
            diff     <= ch0.avg - ch1.avg;
            strobe_d <= ch0.strobe;
            // Shared start, so one channel 0 strobe per measurement
            if (strobe_d) begin
                count <= count + 32'd1;
            end
        end
    end

    // -----------------------------------------------------------------------
    // Sticky overrun flags
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ovr <= 2'b00;
        end else begin
            // New overrun wins over a clear in the same cycle
            ovr <= (ovr & ~clr_ovr) | ovr_set;
        end
    end

endmodule

//--- hdl/delay_regs.sv
`timescale 1ns/1ps
`include "delay_macros.svh"

module delay_regs (
    input  logic                        clk,
    input  logic                        rst,
    // AXI4-Lite write address and data
    input  logic [`DELAY_AXI_AW-1:0]    s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [`DELAY_AXI_DW-1:0]    s_wdata,
    input  logic [`DELAY_AXI_DW/8-1:0]  s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    // Write response
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    // Read address and data
    input  logic [`DELAY_AXI_AW-1:0]    s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`DELAY_AXI_DW-1:0]    s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,
    // Control and status
    output logic                        enable,
    output logic                        slow,
    input  delay_pkg::avg_t             avg0,
    input  delay_pkg::avg_t             avg1,
    input  delay_pkg::avg_t             diff,
    input  logic [31:0]                 count,
    input  logic [1:0]                  ovr,
    output logic [1:0]                  clr_ovr
);
    import delay_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                     wr_en;
    logic                     wr_full;
    logic                     wr_hit;
    reg_addr_e                wr_addr;
    logic                     rd_en;
    logic                     rd_hit;
    reg_addr_e                rd_addr;
    logic [`DELAY_AXI_DW-1:0] rd_data;

    // -----------------------------------------------------------------------
    // Write channel
    // -----------------------------------------------------------------------

    // AW and W taken together, one response outstanding
    assign wr_en     = s_awvalid & s_wvalid & ~s_bvalid;
    assign s_awready = wr_en;
    assign s_wready  = wr_en;
    assign wr_addr   = reg_addr_e'(s_awaddr);
    // Partial strobes change nothing
    assign wr_full   = &s_wstrb;

    always_comb begin
        case (wr_addr)
            REG_CTRL, REG_STATUS, REG_AVG0,
            REG_AVG1, REG_DIFF, REG_COUNT: wr_hit = 1'b1;
            default:                       wr_hit = 1'b0;
        endcase
    end

    // Write 1 to clear, single cycle pulse
    assign clr_ovr = (wr_en && wr_full && wr_addr == REG_STATUS) ? s_wdata[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable   <= 1'b0;
            slow     <= 1'b0;
            s_bvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                s_bvalid <= 1'b1;
                if (wr_full && wr_addr == REG_CTRL) begin
                    enable <= s_wdata[0];
                    slow   <= s_wdata[1];
                end
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            s_bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // -----------------------------------------------------------------------
    // Read channel
    // -----------------------------------------------------------------------
    assign rd_en     = s_arvalid & ~s_rvalid;
    assign s_arready = rd_en;
    assign rd_addr   = reg_addr_e'(s_araddr);

    always_comb begin
        rd_hit = 1'b1;
        case (rd_addr)
            REG_CTRL:   rd_data = {{(`DELAY_AXI_DW-2){1'b0}}, slow, enable};
            REG_STATUS: rd_data = {{(`DELAY_AXI_DW-2){1'b0}}, ovr};
            REG_AVG0:   rd_data = avg0;
            REG_AVG1:   rd_data = avg1;
            REG_DIFF:   rd_data = diff;
            REG_COUNT:  rd_data = count;
            default: begin
                // Unmapped reads as zero
                rd_data = '0;
                rd_hit  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_rvalid <= 1'b0;
        end else if (rd_en) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    // Data captured once per read, held until taken
    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_rdata <= rd_data;
            s_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // -----------------------------------------------------------------------
    // Response handshake
    // -----------------------------------------------------------------------
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (rst) s_bvalid && !s_bready |=> s_bvalid
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
            s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata)
    );

endmodule

//--- hdl/delay_meas_top.sv
`timescale 1ns/1ps
`include "delay_macros.svh"

module delay_meas_top (
    input  logic                        clk,
    input  logic                        rst,
    // Shared start, one stop per path
    input  logic                        start,
    input  logic                        stop0,
    input  logic                        stop1,
    // AXI4-Lite slave
    input  logic [`DELAY_AXI_AW-1:0]    s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [`DELAY_AXI_DW-1:0]    s_wdata,
    input  logic [`DELAY_AXI_DW/8-1:0]  s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    input  logic [`DELAY_AXI_AW-1:0]    s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`DELAY_AXI_DW-1:0]    s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready
);
    logic            enable;
    logic            slow;
    logic [1:0]      clr_ovr;
    logic [1:0]      ovr;
    logic [31:0]     count;
    delay_pkg::avg_t diff;

    // -----------------------------------------------------------------------
    // Channel 0 forward path, channel 1 return path
    // -----------------------------------------------------------------------
    delay_meas_if meas0 ();
    delay_meas_if meas1 ();

    delay_counter counter0_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .start  (start),
        .stop   (stop0),
        .meas   (meas0.counter)
    );

    delay_counter counter1_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .start  (start),
        .stop   (stop1),
        .meas   (meas1.counter)
    );

    delay_average average0_i (
        .clk  (clk),
        .rst  (rst),
        .slow (slow),
        .meas (meas0.averager)
    );

    delay_average average1_i (
        .clk  (clk),
        .rst  (rst),
        .slow (slow),
        .meas (meas1.averager)
    );

    // -----------------------------------------------------------------------
    // Results and register access
    // -----------------------------------------------------------------------
    delay_combine combine_i (
        .clk     (clk),
        .rst     (rst),
        .ch0     (meas0.monitor),
        .ch1     (meas1.monitor),
        .clr_ovr (clr_ovr),
        .diff    (diff),
        .count   (count),
        .ovr     (ovr)
    );

    delay_regs regs_i (
        .clk       (clk),
        .rst       (rst),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .enable    (enable),
        .slow      (slow),
        .avg0      (meas0.avg),
        .avg1      (meas1.avg),
        .diff      (diff),
        .count     (count),
        .ovr       (ovr),
        .clr_ovr   (clr_ovr)
    );

endmodule

//--- dv/delay_meas_tb.sv
`timescale 1ns/1ps
`include "delay_macros.svh"

module delay_meas_tb;
    import delay_pkg::*;

    localparam int ACC_W = `DELAY_OUT_W + `DELAY_N_SLOW + `DELAY_PREC;
    // Cycles allowed for one AXI handshake
    localparam int HS_LIMIT = 100;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       start;
    logic                       stop0;
    logic                       stop1;
    logic [`DELAY_AXI_AW-1:0]   s_awaddr;
    logic                       s_awvalid;
    logic                       s_awready;
    logic [`DELAY_AXI_DW-1:0]   s_wdata;
    logic [`DELAY_AXI_DW/8-1:0] s_wstrb;
    logic                       s_wvalid;
    logic                       s_wready;
    logic [1:0]                 s_bresp;
    logic                       s_bvalid;
    logic                       s_bready;
    logic [`DELAY_AXI_AW-1:0]   s_araddr;
    logic                       s_arvalid;
    logic                       s_arready;
    logic [`DELAY_AXI_DW-1:0]   s_rdata;
    logic [1:0]                 s_rresp;
    logic                       s_rvalid;
    logic                       s_rready;

    // Model state with one accumulator per channel
    integer           seed;
    logic [ACC_W-1:0] acc0;
    logic [ACC_W-1:0] acc1;
    logic [31:0]      exp_count;
    logic [1:0]       resp;
    logic [31:0]      rdata;
    int               d0;

    delay_meas_top delay_meas_top_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stop0     (stop0),
        .stop1     (stop1),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    // ------------------------------------------------------------------------
    // AXI4-Lite master
    // ------------------------------------------------------------------------
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] rsp);
        int waits;
        @(posedge clk);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= '1;
        s_wvalid  <= 1'b1;
        s_bready  <= 1'b1;
        waits = 0;
        // AW and W go in the same cycle
        do begin
            @(posedge clk);
            waits++;
            if (waits > HS_LIMIT) fail_run("Timeout waiting for AW and W to be accepted");
        end while (!(s_awready && s_wready));
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
            if (waits > HS_LIMIT) fail_run("Timeout waiting for the write response");
        end while (!s_bvalid);
        rsp = s_bresp;
        s_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] rsp);
        int waits;
        @(posedge clk);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        s_rready  <= 1'b1;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
            if (waits > HS_LIMIT) fail_run("Timeout waiting for AR to be accepted");
        end while (!s_arready);
        s_arvalid <= 1'b0;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
            if (waits > HS_LIMIT) fail_run("Timeout waiting for read data");
        end while (!s_rvalid);
        data = s_rdata;
        rsp  = s_rresp;
        s_rready <= 1'b0;
    endtask

    // Read one register and expect OKAY with the given value
    task automatic expect_reg(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  rsp;
        axi_read(addr, data, rsp);
        check({name, " resp"}, OKAY, rsp);
        check(name, exp, data);
    endtask

    // Poll until the masked register value matches
    task automatic poll_reg(input string name, input logic [7:0] addr,
                            input logic [31:0] mask, input logic [31:0] want, input int limit);
        int          polls;
        logic [31:0] data;
        logic [1:0]  rsp;
        polls = 0;
        axi_read(addr, data, rsp);
        while ((data & mask) != want) begin
            polls++;
            if (polls > limit) fail_run($sformatf("Timeout polling %s for 0x%08h", name, want));
            axi_read(addr, data, rsp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // acc - acc/2^N + x scaled up by PREC + N_SLOW - N
    function automatic logic [ACC_W-1:0] avg_step(input logic [ACC_W-1:0] acc,
                                                 input logic [15:0] x, input logic slow_mode);
        int n;
        n = slow_mode ? `DELAY_N_SLOW : `DELAY_N_FAST;
        return acc - (acc >> n) + (ACC_W'(x) << (`DELAY_PREC + `DELAY_N_SLOW - n));
    endfunction

    // Upper 32 bits of the accumulator shifted left by 16
    function automatic logic [31:0] avg_word(input logic [ACC_W-1:0] acc);
        logic [ACC_W-1:0] sh;
        sh = acc << 16;
        return sh[ACC_W-1 -: 32];
    endfunction

    // Uniform in 1..200
    function automatic int rand_delay();
        return 1 + ($unsigned($random(seed)) % 200);
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Start at edge t with stop pulses sampled at t + d0 and t + d1
    task automatic measure(input int dly0, input int dly1, input logic skip1);
        int i;
        int dmax;
        dmax = (skip1 || dly0 > dly1) ? dly0 : dly1;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (i = 1; i <= dmax; i++) begin
            stop0 <= (i == dly0);
            stop1 <= (i == dly1) && !skip1;
            @(posedge clk);
        end
        stop0 <= 1'b0;
        stop1 <= 1'b0;
        // diff settles three edges after the last stop
        repeat (3) @(posedge clk);
    endtask

    task automatic verify_outputs(input string tag);
        expect_reg({tag, " AVG0"}, REG_AVG0, avg_word(acc0));
        expect_reg({tag, " AVG1"}, REG_AVG1, avg_word(acc1));
        expect_reg({tag, " DIFF"}, REG_DIFF, avg_word(acc0) - avg_word(acc1));
        expect_reg({tag, " COUNT"}, REG_COUNT, exp_count);
    endtask

    task automatic run_random(input int n, input logic slow_mode, input string tag);
        int k;
        int r0;
        int r1;
        for (k = 0; k < n; k++) begin
            r0 = rand_delay();
            r1 = rand_delay();
            measure(r0, r1, 1'b0);
            acc0 = avg_step(acc0, r0, slow_mode);
            acc1 = avg_step(acc1, r1, slow_mode);
            exp_count++;
            poll_reg("COUNT", REG_COUNT, '1, exp_count, 50);
            verify_outputs($sformatf("%s %0d", tag, k));
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        stop0     = 1'b0;
        stop1     = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        seed      = 38871;
        acc0      = '0;
        acc1      = '0;
        exp_count = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset values, CTRL readback, unmapped access
        expect_reg("reset CTRL", REG_CTRL, 32'h0);
        expect_reg("reset STATUS", REG_STATUS, 32'h0);
        expect_reg("reset AVG0", REG_AVG0, 32'h0);
        expect_reg("reset AVG1", REG_AVG1, 32'h0);
        expect_reg("reset DIFF", REG_DIFF, 32'h0);
        expect_reg("reset COUNT", REG_COUNT, 32'h0);
        axi_write(REG_CTRL, 32'h3, resp);
        check("CTRL write resp", OKAY, resp);
        expect_reg("CTRL readback", REG_CTRL, 32'h3);
        axi_write(REG_CTRL, 32'h0, resp);
        expect_reg("CTRL cleared", REG_CTRL, 32'h0);
        axi_write(8'h20, 32'h1234, resp);
        check("unmapped write resp", SLVERR, resp);
        axi_read(8'h20, rdata, resp);
        check("unmapped read resp", SLVERR, resp);
        check("unmapped read data", 32'h0, rdata);

        // Disabled counters ignore start
        measure(5, 7, 1'b0);
        expect_reg("disabled COUNT", REG_COUNT, 32'h0);
        expect_reg("disabled AVG0", REG_AVG0, 32'h0);

        axi_write(REG_CTRL, 32'h1, resp);
        run_random(40, 1'b0, "fast");
        axi_write(REG_CTRL, 32'h3, resp);
        run_random(30, 1'b1, "slow");

        // Return path lost so channel 1 times out
        repeat (2) begin
            d0 = rand_delay();
            measure(d0, 0, 1'b1);
            acc0 = avg_step(acc0, d0, 1'b1);
            exp_count++;
            poll_reg("COUNT", REG_COUNT, '1, exp_count, 50);
            poll_reg("STATUS overrun1", REG_STATUS, 32'h2, 32'h2, 40000);
            acc1 = avg_step(acc1, `DELAY_MAX_CYC, 1'b1);
            verify_outputs("overrun");
            expect_reg("overrun STATUS", REG_STATUS, 32'h2);
            axi_write(REG_STATUS, 32'h2, resp);
            expect_reg("STATUS cleared", REG_STATUS, 32'h0);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- delay_meas_top.f
+incdir+include
hdl/delay_pkg.sv
hdl/delay_meas_if.sv
hdl/delay_counter.sv
hdl/delay_average.sv
hdl/delay_combine.sv
hdl/delay_regs.sv
hdl/delay_meas_top.sv
dv/delay_meas_tb.sv

//--- Bender.yml
package:
  name: delay_meas

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/delay_pkg.sv
      - hdl/delay_meas_if.sv
      - hdl/delay_counter.sv
      - hdl/delay_average.sv
      - hdl/delay_combine.sv
      - hdl/delay_regs.sv
      - hdl/delay_meas_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/delay_meas_tb.sv
